// ==== all.f ====
common/axi_types_pkg.sv
common/splitter_cfg_pkg.sv
ax_split/len_tracker.sv
ax_split/ax_splitter.sv
hdl/resp_joiner.sv
hdl/burst_splitter_top.sv
testbench/tb_burst_splitter.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_burst_splitter -f all.f --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "All checks passed" sim.log; then
  exit 0
fi
echo "Simulation did not report a pass" >&2
exit 1

// ==== testbench/tb_burst_splitter.sv ====
// Directed testbench for the burst splitter with a single-beat subordinate model
`default_nettype none

module tb_burst_splitter
  import axi_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TEST_COUNT      = 5;
  localparam int unsigned CYCLES_PER_TEST = 80;
  localparam int unsigned TIMEOUT_CYCLES  = TEST_COUNT * CYCLES_PER_TEST * 5;

  logic    clk_i        = 1'b0;
  logic    reset_i      = 1'b1;
  ax_req_t s_aw_i       = '0;
  logic    s_aw_valid_i = 1'b0;
  logic    s_aw_ready_o;
  w_beat_t s_w_i        = '0;
  logic    s_w_valid_i  = 1'b0;
  logic    s_w_ready_o;
  b_rsp_t  s_b_o;
  logic    s_b_valid_o;
  logic    s_b_ready_i  = 1'b1;
  ax_req_t s_ar_i       = '0;
  logic    s_ar_valid_i = 1'b0;
  logic    s_ar_ready_o;
  r_beat_t s_r_o;
  logic    s_r_valid_o;
  logic    s_r_ready_i  = 1'b1;
  ax_req_t m_aw_o;
  logic    m_aw_valid_o;
  logic    m_aw_ready_i = 1'b0;
  w_beat_t m_w_o;
  logic    m_w_valid_o;
  logic    m_w_ready_i  = 1'b1;
  b_rsp_t  m_b_i        = '0;
  logic    m_b_valid_i  = 1'b0;
  logic    m_b_ready_o;
  ax_req_t m_ar_o;
  logic    m_ar_valid_o;
  logic    m_ar_ready_i = 1'b0;
  r_beat_t m_r_i        = '0;
  logic    m_r_valid_i  = 1'b0;
  logic    m_r_ready_o;

  logic [31:0] lfsr_q      = 32'h4b9e_5ba6;
  logic        r_bp_en     = 1'b0;
  int          err_count   = 0;
  int          w_avail     = 0;
  int unsigned cycle_count = 0;

  // Downstream traffic and upstream responses seen so far
  ax_req_t aw_log[$];
  ax_req_t ar_log[$];
  ax_req_t aw_pend[$];
  ax_req_t ar_pend[$];
  w_beat_t w_log[$];
  b_rsp_t  b_got[$];
  r_beat_t r_got[$];
  // Sub-response codes handed out by the subordinate in order with OKAY once empty
  resp_t   b_resp_tab[$];

  burst_splitter_top u_burst_splitter_top (.*);

  always #4 clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // ----------------------------------------
  // Subordinate model and monitors
  // ----------------------------------------
  always @(posedge clk_i) begin
    b_rsp_t  nb;
    r_beat_t nr;
    ax_req_t req;
    lfsr_q = lfsr_step(lfsr_q);
    m_aw_ready_i <= lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    m_ar_ready_i <= lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    m_w_ready_i <= lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    s_b_ready_i <= lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    s_r_ready_i <= r_bp_en ? lfsr_q[0] : 1'b1;
    if (reset_i) begin
      m_b_valid_i <= 1'b0;
      m_r_valid_i <= 1'b0;
      w_avail = 0;
    end else begin
      if (m_aw_valid_o && m_aw_ready_i) begin
        aw_log.push_back(m_aw_o);
        aw_pend.push_back(m_aw_o);
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        ar_log.push_back(m_ar_o);
        ar_pend.push_back(m_ar_o);
      end
      if (m_w_valid_o && m_w_ready_i) begin
        w_log.push_back(m_w_o);
        w_avail++;
      end
      if (s_b_valid_o && s_b_ready_i) begin
        b_got.push_back(s_b_o);
      end
      if (s_r_valid_o && s_r_ready_i) begin
        r_got.push_back(s_r_o);
      end
      // A write answers only once its data beat has arrived
      if (!m_b_valid_i || m_b_ready_o) begin
        if (aw_pend.size() > 0 && w_avail > 0) begin
          req = aw_pend.pop_front();
          w_avail--;
          nb.id = req.id;
          if (b_resp_tab.size() > 0) begin
            nb.resp = b_resp_tab.pop_front();
          end else begin
            nb.resp = OKAY;
          end
          m_b_i       <= nb;
          m_b_valid_i <= 1'b1;
        end else begin
          m_b_valid_i <= 1'b0;
        end
      end
      if (!m_r_valid_i || m_r_ready_o) begin
        if (ar_pend.size() > 0) begin
          req = ar_pend.pop_front();
          nr.id   = req.id;
          nr.data = req.addr;
          nr.resp = OKAY;
          nr.last = 1'b1;
          m_r_i       <= nr;
          m_r_valid_i <= 1'b1;
        end else begin
          m_r_valid_i <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Run timed out after %0d cycles waiting for a response", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Expected values
  // ----------------------------------------
  function automatic ax_req_t make_req(input id_t id, input addr_t addr, input len_t len,
                                       input size_t size, input burst_t burst);
    ax_req_t r;
    r.id    = id;
    r.addr  = addr;
    r.len   = len;
    r.size  = size;
    r.burst = burst;
    return r;
  endfunction

  // One beat of a burst as a single request
  function automatic ax_req_t expected_sub(input ax_req_t req, input int beat);
    ax_req_t sub;
    sub     = req;
    sub.len = '0;
    if (req.burst == INCR) begin
      sub.addr = req.addr + (addr_t'(beat) << req.size);
    end
    return sub;
  endfunction

  // An error on any earlier beat gives SLVERR and otherwise the final beat's own code
  function automatic resp_t merged_b_resp(input len_t len);
    resp_t sub;
    resp_t merged;
    logic  err;
    err    = 1'b0;
    merged = OKAY;
    for (int i = 0; i <= int'(len); i++) begin
      sub = (i < b_resp_tab.size()) ? b_resp_tab[i] : OKAY;
      if (i == int'(len)) begin
        merged = err ? SLVERR : sub;
      end else if (sub[1]) begin
        err = 1'b1;
      end
    end
    return merged;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_ax(input ax_req_t got, input ax_req_t exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_w(input w_beat_t got, input w_beat_t exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_b(input b_rsp_t got, input b_rsp_t exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_r(input r_beat_t got, input r_beat_t exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string msg);
    if (got != exp) begin
      $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_requests(input logic is_read, input ax_req_t req, input int base);
    int n;
    n = is_read ? ar_log.size() : aw_log.size();
    for (int i = 0; i <= int'(req.len); i++) begin
      if (base + i < n) begin
        check_ax(is_read ? ar_log[base + i] : aw_log[base + i], expected_sub(req, i),
                 "downstream sub-request");
      end
    end
  endtask

  task automatic check_read_beats(input ax_req_t req, input int base);
    r_beat_t exp_r;
    ax_req_t sub;
    for (int i = 0; i <= int'(req.len); i++) begin
      sub        = expected_sub(req, i);
      exp_r.id   = req.id;
      exp_r.data = sub.addr;
      exp_r.resp = OKAY;
      exp_r.last = (i == int'(req.len));
      if (base + i < r_got.size()) begin
        check_r(r_got[base + i], exp_r, "upstream R beat");
      end
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic send_addr(input logic is_read, input ax_req_t req);
    if (is_read) begin
      s_ar_i       <= req;
      s_ar_valid_i <= 1'b1;
    end else begin
      s_aw_i       <= req;
      s_aw_valid_i <= 1'b1;
    end
    @(posedge clk_i);
    while (!(is_read ? s_ar_ready_o : s_aw_ready_o)) begin
      @(posedge clk_i);
    end
    s_ar_valid_i <= 1'b0;
    s_aw_valid_i <= 1'b0;
  endtask

  task automatic send_w(input int n);
    w_beat_t w;
    for (int i = 0; i < n; i++) begin
      w.data = 32'hd000_0000 + data_t'(i);
      w.strb = 4'hf;
      w.last = (i == n - 1);
      s_w_i       <= w;
      s_w_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!s_w_ready_o) begin
        @(posedge clk_i);
      end
    end
    s_w_valid_i <= 1'b0;
  endtask

  task automatic clear_logs();
    aw_log.delete();
    ar_log.delete();
    w_log.delete();
    b_got.delete();
    r_got.delete();
  endtask

  // Quiet window so that any extra response shows up in the counts
  task automatic settle();
    repeat (8) @(posedge clk_i);
  endtask

  task automatic run_write(input ax_req_t req);
    resp_t   exp_resp;
    b_rsp_t  exp_b;
    w_beat_t exp_w;
    exp_resp = merged_b_resp(req.len);
    clear_logs();
    send_addr(1'b0, req);
    send_w(int'(req.len) + 1);
    while (b_got.size() < 1) begin
      @(posedge clk_i);
    end
    settle();
    check_count(aw_log.size(), int'(req.len) + 1, "downstream AW count");
    check_requests(1'b0, req, 0);
    check_count(w_log.size(), int'(req.len) + 1, "downstream W count");
    for (int i = 0; i < w_log.size(); i++) begin
      exp_w.data = 32'hd000_0000 + data_t'(i);
      exp_w.strb = 4'hf;
      exp_w.last = 1'b1;
      check_w(w_log[i], exp_w, "downstream W beat");
    end
    check_count(b_got.size(), 1, "upstream B count");
    exp_b.id   = req.id;
    exp_b.resp = exp_resp;
    check_b(b_got[0], exp_b, "merged B response");
  endtask

  task automatic run_reads(input ax_req_t req_a, input ax_req_t req_b, input logic two);
    int total;
    total = int'(req_a.len) + 1 + (two ? int'(req_b.len) + 1 : 0);
    clear_logs();
    send_addr(1'b1, req_a);
    if (two) begin
      send_addr(1'b1, req_b);
    end
    while (r_got.size() < total) begin
      @(posedge clk_i);
    end
    settle();
    check_count(ar_log.size(), total, "downstream AR count");
    check_count(r_got.size(), total, "upstream R count");
    check_requests(1'b1, req_a, 0);
    check_read_beats(req_a, 0);
    if (two) begin
      check_requests(1'b1, req_b, int'(req_a.len) + 1);
      check_read_beats(req_b, int'(req_a.len) + 1);
    end
  endtask

  initial begin
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    // Single-beat write
    run_write(make_req(4'h3, 32'h100, 8'd0, 3'd2, INCR));
    // INCR write burst
    run_write(make_req(4'h5, 32'h200, 8'd3, 3'd2, INCR));
    // FIXED read burst
    run_reads(make_req(4'h2, 32'h300, 8'd2, 3'd2, FIXED), '0, 1'b0);
    // Error merge, then a clean burst to show the sticky bit cleared
    b_resp_tab = '{OKAY, SLVERR, OKAY, OKAY};
    run_write(make_req(4'h6, 32'h600, 8'd3, 3'd2, INCR));
    run_write(make_req(4'h7, 32'h700, 8'd1, 3'd2, INCR));
    // Two reads in flight with upstream R back-pressure
    r_bp_en <= 1'b1;
    run_reads(make_req(4'h1, 32'h400, 8'd3, 3'd2, INCR),
              make_req(4'h4, 32'h500, 8'd1, 3'd2, INCR), 1'b1);
    r_bp_en <= 1'b0;

    $display("Finished with %0d errors", err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/burst_splitter_top.sv ====
// Burst splitter that turns AXI bursts into single-beat requests downstream
`default_nettype none

module burst_splitter_top
  import axi_types_pkg::*;
  import splitter_cfg_pkg::*;
(
  input  wire     clk_i,
  input  wire     reset_i,
  // Upstream manager side
  input  ax_req_t s_aw_i,
  input  logic    s_aw_valid_i,
  output logic    s_aw_ready_o,
  input  w_beat_t s_w_i,
  input  logic    s_w_valid_i,
  output logic    s_w_ready_o,
  output b_rsp_t  s_b_o,
  output logic    s_b_valid_o,
  input  logic    s_b_ready_i,
  input  ax_req_t s_ar_i,
  input  logic    s_ar_valid_i,
  output logic    s_ar_ready_o,
  output r_beat_t s_r_o,
  output logic    s_r_valid_o,
  input  logic    s_r_ready_i,
  // Downstream subordinate side
  output ax_req_t m_aw_o,
  output logic    m_aw_valid_o,
  input  logic    m_aw_ready_i,
  output w_beat_t m_w_o,
  output logic    m_w_valid_o,
  input  logic    m_w_ready_i,
  input  b_rsp_t  m_b_i,
  input  logic    m_b_valid_i,
  output logic    m_b_ready_o,
  output ax_req_t m_ar_o,
  output logic    m_ar_valid_o,
  input  logic    m_ar_ready_i,
  input  r_beat_t m_r_i,
  input  logic    m_r_valid_i,
  output logic    m_r_ready_o
);

  len_t w_cnt_left;
  logic w_cnt_valid;
  logic w_cnt_dec;
  len_t r_cnt_left;
  logic r_cnt_valid;
  logic r_cnt_dec;

  // ----------------------------------------
  // Address channels
  // ----------------------------------------
  ax_splitter #(
    .DEPTH(MAX_WRITE_TXNS)
  ) u_aw_split (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ax_i        (s_aw_i),
    .ax_valid_i  (s_aw_valid_i),
    .ax_ready_o  (s_aw_ready_o),
    .ax_o        (m_aw_o),
    .ax_valid_o  (m_aw_valid_o),
    .ax_ready_i  (m_aw_ready_i),
    .cnt_left_o  (w_cnt_left),
    .cnt_valid_o (w_cnt_valid),
    .cnt_dec_i   (w_cnt_dec)
  );

  ax_splitter #(
    .DEPTH(MAX_READ_TXNS)
  ) u_ar_split (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .ax_i        (s_ar_i),
    .ax_valid_i  (s_ar_valid_i),
    .ax_ready_o  (s_ar_ready_o),
    .ax_o        (m_ar_o),
    .ax_valid_o  (m_ar_valid_o),
    .ax_ready_i  (m_ar_ready_i),
    .cnt_left_o  (r_cnt_left),
    .cnt_valid_o (r_cnt_valid),
    .cnt_dec_i   (r_cnt_dec)
  );

  // ----------------------------------------
  // Write data
  // ----------------------------------------
  // Every beat is its own transaction downstream, so each one is the last
  always_comb begin
    m_w_o      = s_w_i;
    m_w_o.last = 1'b1;
  end
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  // ----------------------------------------
  // Responses
  // ----------------------------------------
  resp_joiner u_resp (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .m_b_i        (m_b_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o),
    .s_b_o        (s_b_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .m_r_i        (m_r_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .s_r_o        (s_r_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .wcnt_left_i  (w_cnt_left),
    .wcnt_valid_i (w_cnt_valid),
    .wcnt_dec_o   (w_cnt_dec),
    .rcnt_left_i  (r_cnt_left),
    .rcnt_valid_i (r_cnt_valid),
    .rcnt_dec_o   (r_cnt_dec)
  );

endmodule

`default_nettype wire

// ==== hdl/resp_joiner.sv ====
// Write response merge with sticky error and read last rebuild
`default_nettype none

module resp_joiner
  import axi_types_pkg::*;
(
  input  wire     clk_i,
  input  wire     reset_i,
  // Write responses
  input  b_rsp_t  m_b_i,
  input  logic    m_b_valid_i,
  output logic    m_b_ready_o,
  output b_rsp_t  s_b_o,
  output logic    s_b_valid_o,
  input  logic    s_b_ready_i,
  // Read data
  input  r_beat_t m_r_i,
  input  logic    m_r_valid_i,
  output logic    m_r_ready_o,
  output r_beat_t s_r_o,
  output logic    s_r_valid_o,
  input  logic    s_r_ready_i,
  // Write tracker
  input  len_t    wcnt_left_i,
  input  logic    wcnt_valid_i,
  output logic    wcnt_dec_o,
  // Read tracker
  input  len_t    rcnt_left_i,
  input  logic    rcnt_valid_i,
  output logic    rcnt_dec_o
);

  logic b_final;
  logic b_hs;
  logic b_err_q;
  logic r_hs;

  // ----------------------------------------
  // B channel
  // ----------------------------------------
  assign b_final = (wcnt_left_i == '0);

  // Sub-responses before the final one are swallowed without waiting upstream
  assign m_b_ready_o = wcnt_valid_i && (b_final ? s_b_ready_i : 1'b1);
  assign s_b_valid_o = m_b_valid_i && wcnt_valid_i && b_final;

  always_comb begin
    s_b_o = m_b_i;
    if (b_err_q) begin
      s_b_o.resp = SLVERR;
    end
  end

  assign b_hs       = m_b_valid_i && m_b_ready_o;
  assign wcnt_dec_o = b_hs;

  // Error seen on an earlier beat of the current burst
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_err_q <= 1'b0;
    end else if (b_hs) begin
      if (b_final) begin
        b_err_q <= 1'b0;
      end else if (m_b_i.resp[1]) begin
        b_err_q <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // R channel
  // ----------------------------------------
  assign m_r_ready_o = rcnt_valid_i && s_r_ready_i;
  assign s_r_valid_o = m_r_valid_i && rcnt_valid_i;

  always_comb begin
    s_r_o      = m_r_i;
    s_r_o.last = (rcnt_left_i == '0);
  end

  assign r_hs       = m_r_valid_i && m_r_ready_o;
  assign rcnt_dec_o = r_hs;

endmodule

`default_nettype wire

// ==== ax_split/ax_splitter.sv ====
// Address channel splitter issuing one single-beat request per burst beat
`default_nettype none

module ax_splitter
  import axi_types_pkg::*;
  import splitter_cfg_pkg::*;
#(
  parameter int unsigned DEPTH = MAX_WRITE_TXNS
) (
  input  wire     clk_i,
  input  wire     reset_i,
  // Upstream burst
  input  ax_req_t ax_i,
  input  logic    ax_valid_i,
  output logic    ax_ready_o,
  // Downstream single-beat requests
  output ax_req_t ax_o,
  output logic    ax_valid_o,
  input  logic    ax_ready_i,
  // Length query for the response side
  output len_t    cnt_left_o,
  output logic    cnt_valid_o,
  input  logic    cnt_dec_i
);

  split_state_t state_q;
  ax_req_t      ax_q;
  logic         trk_full;
  logic         in_hs;
  logic         out_hs;
  addr_t        addr_step;

  assign ax_ready_o = (state_q == IDLE) && !trk_full;
  assign in_hs      = ax_valid_i && ax_ready_o;
  assign out_hs     = ax_valid_o && ax_ready_i;

  // Offer the stored burst as a single beat
  always_comb begin
    ax_o     = ax_q;
    ax_o.len = '0;
  end
  assign ax_valid_o = (state_q == BUSY);

  assign addr_step = addr_t'(1) << ax_q.size;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (in_hs) begin
            state_q <= BUSY;
          end
        end
        BUSY: begin
          // Stored len of zero means this handshake sent the final beat
          if (out_hs && ax_q.len == '0) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Request payload
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (in_hs) begin
      ax_q <= ax_i;
    end else if (out_hs && ax_q.len != '0) begin
      ax_q.len <= ax_q.len - len_t'(1);
      // FIXED and the unsupported WRAP keep the same address
      if (ax_q.burst == INCR) begin
        ax_q.addr <= ax_q.addr + addr_step;
      end
    end
  end

  len_tracker #(
    .DEPTH(DEPTH)
  ) u_len_tracker (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (in_hs),
    .push_len_i  (ax_i.len),
    .full_o      (trk_full),
    .cnt_left_o  (cnt_left_o),
    .cnt_valid_o (cnt_valid_o),
    .cnt_dec_i   (cnt_dec_i)
  );

endmodule

`default_nettype wire

// ==== ax_split/len_tracker.sv ====
// In-order FIFO of burst lengths whose head entry counts down per response beat
`default_nettype none

module len_tracker
  import axi_types_pkg::*;
  import splitter_cfg_pkg::*;
#(
  parameter int unsigned DEPTH = MAX_WRITE_TXNS
) (
  input  wire  clk_i,
  input  wire  reset_i,
  // Burst accepted upstream
  input  logic push_i,
  input  len_t push_len_i,
  output logic full_o,
  // Beats left in the head burst after the current one
  output len_t cnt_left_o,
  output logic cnt_valid_o,
  input  logic cnt_dec_i
);

  len_t       len_mem [DEPTH];
  track_idx_t wr_ptr_q;
  track_idx_t rd_ptr_q;
  track_cnt_t count_q;
  logic       do_push;
  logic       do_dec;
  logic       do_pop;

  assign full_o      = (count_q == track_cnt_t'(DEPTH));
  assign cnt_valid_o = (count_q != '0);
  assign cnt_left_o  = len_mem[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_dec  = cnt_dec_i && cnt_valid_o;
  // Decrement at zero retires the burst
  assign do_pop  = do_dec && (cnt_left_o == '0);

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == track_idx_t'(DEPTH - 1)) ? '0 : wr_ptr_q + track_idx_t'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == track_idx_t'(DEPTH - 1)) ? '0 : rd_ptr_q + track_idx_t'(1);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + track_cnt_t'(1);
        2'b01:   count_q <= count_q - track_cnt_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------
  // Length storage
  // ----------------------------------------
  // A push never lands on the counting head entry because the FIFO is not full then
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      len_mem[wr_ptr_q] <= push_len_i;
    end
    if (do_dec && !do_pop) begin
      len_mem[rd_ptr_q] <= len_mem[rd_ptr_q] - len_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== common/splitter_cfg_pkg.sv ====
// Splitter sizing constants, tracker index and count types, splitter states
`default_nettype none

package splitter_cfg_pkg;

  // Bursts that may be outstanding per direction
  localparam int unsigned MAX_WRITE_TXNS = 4;
  localparam int unsigned MAX_READ_TXNS  = 4;

  // Pointer width of the length FIFO
  localparam int unsigned TRACK_IDX_W = 2;

  typedef logic [TRACK_IDX_W-1:0] track_idx_t;
  // One bit wider than the pointers so a full FIFO can be told from an empty one
  typedef logic [TRACK_IDX_W:0]   track_cnt_t;

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } split_state_t;

endpackage

`default_nettype wire

// ==== common/axi_types_pkg.sv ====
// AXI field types, response and burst encodings, and packed channel structs
`default_nettype none

package axi_types_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  // Beats in a burst minus one
  typedef logic [7:0]  len_t;
  // Log2 of the bytes moved per beat
  typedef logic [2:0]  size_t;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_t;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------
  // Shared by AW and AR
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ax_req_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_beat_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_rsp_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_beat_t;

endpackage

`default_nettype wire
